/* Makefile */
TOP = tb_decode_stage
LOG = sim.log

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps -j 0 \
	  --top-module $(TOP) -Mdir obj_dir -f files.f

run: compile
	./obj_dir/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Regression failed" $(LOG); then echo "Simulation reported errors"; exit 1; fi
	@grep -q "Regression passed" $(LOG) || (echo "Simulation ended without a result"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

/* de_cases.txt */
// valid inst pc bhr br_mispred wb_en wb_rd wb_value | exp: stall op rs1_val rs2_val imm flags
// flags = {is_br, is_jmp, rd_mem, wr_mem, wr_reg}; a stalled line expects an all-zero bubble
1 ffd00293 00001000 a1 0 0 00 00000000 0 0c 00000000 00000000 fffffffd 01
1 00500493 00001004 a2 0 1 05 12345678 0 0c 00000000 12345678 00000005 01
1 00028433 00001008 a3 0 0 00 00000000 0 01 12345678 00000000 00000000 01
1 40500533 0000100c a4 0 1 00 deadbeef 0 02 00000000 12345678 00000000 01
1 fe502e23 00001010 a5 0 0 00 00000000 0 18 00000000 12345678 fffffffc 02
1 0102a383 00001014 a6 0 0 00 00000000 0 17 12345678 00000000 00000010 05
1 fe538ce3 00001018 a7 0 0 00 00000000 1 00 00000000 00000000 00000000 00
1 fe538ce3 00001018 a7 0 1 07 87654321 1 00 00000000 00000000 00000000 00
1 fe538ce3 00001018 a7 0 0 00 00000000 0 1b 87654321 12345678 fffffff8 10
1 ffdff0ef 00001040 b0 1 0 00 00000000 1 00 00000000 00000000 00000000 00
1 ffdff0ef 00001040 b0 0 0 00 00000000 0 19 00000000 00000000 fffffffc 09
0 007085b3 00001044 b1 0 0 00 00000000 0 01 00000000 87654321 00000000 01
1 02209133 00001048 b2 0 0 00 00000000 0 00 00000000 00000000 00000000 00
1 4042d613 0000104c b3 0 0 00 00000000 0 12 12345678 00000000 00000404 01
1 fffff697 00001050 b4 0 0 00 00000000 0 16 00000000 00000000 fffff000 01

/* decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
  input  wire                      clk,
  input  wire                      reset,
  input  wire pipe_pkg::fe_latch_t fe_latch,
  input  wire                      br_mispred,
  input  wire pipe_pkg::wb_write_t wb,
  output logic                     stall,
  output pipe_pkg::de_latch_t      de_latch_out
);

  pipe_pkg::dec_ctrl_t ctrl;
  pipe_pkg::de_latch_t de_next;
  pipe_pkg::de_latch_t de_latch;
  isa_pkg::xlen_t      imm;
  isa_pkg::xlen_t      rs1_val;
  isa_pkg::xlen_t      rs2_val;

  ////////////////////
  // Decode blocks

  inst_decoder u_dec (
    .inst (fe_latch.inst),
    .ctrl (ctrl)
  );

  imm_gen u_imm (
    .inst (fe_latch.inst),
    .kind (ctrl.imm_kind),
    .imm  (imm)
  );

  reg_file u_rf (
    .clk     (clk),
    .reset   (reset),
    .rs1     (fe_latch.inst.r.rs1),
    .rs2     (fe_latch.inst.r.rs2),
    .wb      (wb),
    .rs1_val (rs1_val),
    .rs2_val (rs2_val)
  );

  scoreboard u_sb (
    .clk        (clk),
    .reset      (reset),
    .valid      (fe_latch.valid),
    .rs1        (fe_latch.inst.r.rs1),
    .rs2        (fe_latch.inst.r.rs2),
    .rd         (fe_latch.inst.r.rd),
    .use_rs1    (ctrl.use_rs1),
    .use_rs2    (ctrl.use_rs2),
    .wr_reg     (ctrl.wr_reg),
    .br_mispred (br_mispred),
    .wb         (wb),
    .stall      (stall)
  );

  ////////////////////
  // Next latch contents

  always_comb begin
    de_next.valid    = fe_latch.valid;
    de_next.inst     = fe_latch.inst;
    de_next.pc       = fe_latch.pc;
    de_next.pc_plus  = fe_latch.pc_plus;
    de_next.pc_next  = fe_latch.pc_next;
    de_next.op       = ctrl.op;
    de_next.rs1_val  = rs1_val;
    de_next.rs2_val  = rs2_val;
    de_next.imm      = imm;
    de_next.is_br    = ctrl.is_br;
    de_next.is_jmp   = ctrl.is_jmp;
    de_next.rd_mem   = ctrl.rd_mem;
    de_next.wr_mem   = ctrl.wr_mem;
    de_next.wr_reg   = ctrl.wr_reg;
    de_next.rd       = fe_latch.inst.r.rd;
    de_next.bhr_hash = fe_latch.bhr_hash;
  end

  always_ff @(posedge clk) begin
    if (reset)
      de_latch <= '0;
    else if (stall)
      de_latch <= '0; // Bubble, fetch holds its latch meanwhile
    else
      de_latch <= de_next;
  end

  assign de_latch_out = de_latch;

  a_stall_bubble: assert property (@(posedge clk) disable iff (reset)
    stall |=> !de_latch_out.valid)
    else $error("stalled slot reached execute");

endmodule

`default_nettype wire

/* files.f */
isa_pkg.sv
pipe_pkg.sv
inst_decoder.sv
imm_gen.sv
reg_file.sv
scoreboard.sv
decode_stage.sv
tb_decode_stage.sv

/* imm_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module imm_gen (
  input  wire isa_pkg::inst_u     inst,
  input  wire isa_pkg::imm_kind_e kind,
  output isa_pkg::xlen_t          imm
);

  always_comb begin
    case (kind)
      isa_pkg::IMM_I: imm = {{20{inst.i.imm[11]}}, inst.i.imm};
      isa_pkg::IMM_S: imm = {{20{inst.s.imm_11_5[6]}}, inst.s.imm_11_5, inst.s.imm_4_0};
      isa_pkg::IMM_B: begin
        // Branch offsets are halfword aligned
        imm = {{19{inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
               inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
      end
      isa_pkg::IMM_U: imm = {inst.u.imm_31_12, 12'b0}; // Upper 20 bits only
      isa_pkg::IMM_J: begin
        imm = {{11{inst.j.imm_20}}, inst.j.imm_20, inst.j.imm_19_12,
               inst.j.imm_11, inst.j.imm_10_1, 1'b0};
      end
      isa_pkg::IMM_NONE: imm = '0;
      default:           imm = '0;
    endcase
  end

endmodule

`default_nettype wire

/* inst_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module inst_decoder (
  input  wire isa_pkg::inst_u inst,
  output pipe_pkg::dec_ctrl_t ctrl
);

  isa_pkg::iop_e op;
  logic          writes; // Op produces a register result

  ////////////////////
  // Opcode match

  always_comb begin
    op = isa_pkg::IOP_INVALID;
    case (inst.r.opcode)
      isa_pkg::OP_OP: begin
        if (inst.r.funct7 == isa_pkg::F7_BASE) begin
          case (inst.r.funct3)
            isa_pkg::F3_ADD_SUB: op = isa_pkg::IOP_ADD;
            isa_pkg::F3_SLL:     op = isa_pkg::IOP_SLL;
            isa_pkg::F3_SLT:     op = isa_pkg::IOP_SLT;
            isa_pkg::F3_SLTU:    op = isa_pkg::IOP_SLTU;
            isa_pkg::F3_XOR:     op = isa_pkg::IOP_XOR;
            isa_pkg::F3_SRL_SRA: op = isa_pkg::IOP_SRL;
            isa_pkg::F3_OR:      op = isa_pkg::IOP_OR;
            isa_pkg::F3_AND:     op = isa_pkg::IOP_AND;
            default:             op = isa_pkg::IOP_INVALID;
          endcase
        end else if (inst.r.funct7 == isa_pkg::F7_ALT) begin
          if (inst.r.funct3 == isa_pkg::F3_ADD_SUB) op = isa_pkg::IOP_SUB;
          if (inst.r.funct3 == isa_pkg::F3_SRL_SRA) op = isa_pkg::IOP_SRA;
        end else if (inst.r.funct7 == isa_pkg::F7_MUL && inst.r.funct3 == isa_pkg::F3_MUL) begin
          op = isa_pkg::IOP_MUL; // Only MUL from the M group
        end
      end
      isa_pkg::OP_IMM: begin
        case (inst.i.funct3)
          isa_pkg::F3_ADD_SUB: op = isa_pkg::IOP_ADDI;
          isa_pkg::F3_SLT:     op = isa_pkg::IOP_SLTI;
          isa_pkg::F3_SLTU:    op = isa_pkg::IOP_SLTIU;
          isa_pkg::F3_XOR:     op = isa_pkg::IOP_XORI;
          isa_pkg::F3_OR:      op = isa_pkg::IOP_ORI;
          isa_pkg::F3_AND:     op = isa_pkg::IOP_ANDI;
          isa_pkg::F3_SLL: begin
            if (inst.r.funct7 == isa_pkg::F7_BASE) op = isa_pkg::IOP_SLLI;
          end
          isa_pkg::F3_SRL_SRA: begin // Shift kind sits in the upper imm bits
            if (inst.r.funct7 == isa_pkg::F7_BASE) op = isa_pkg::IOP_SRLI;
            if (inst.r.funct7 == isa_pkg::F7_ALT) op = isa_pkg::IOP_SRAI;
          end
          default: op = isa_pkg::IOP_INVALID;
        endcase
      end
      isa_pkg::OP_LUI:   op = isa_pkg::IOP_LUI;
      isa_pkg::OP_AUIPC: op = isa_pkg::IOP_AUIPC;
      isa_pkg::OP_JAL:   op = isa_pkg::IOP_JAL;
      isa_pkg::OP_LOAD: begin
        if (inst.i.funct3 == isa_pkg::F3_LW) op = isa_pkg::IOP_LW;
      end
      isa_pkg::OP_STORE: begin
        if (inst.i.funct3 == isa_pkg::F3_SW) op = isa_pkg::IOP_SW;
      end
      isa_pkg::OP_JALR: begin
        if (inst.i.funct3 == isa_pkg::F3_JALR) op = isa_pkg::IOP_JALR;
      end
      isa_pkg::OP_BRANCH: begin
        case (inst.i.funct3)
          isa_pkg::F3_BEQ:  op = isa_pkg::IOP_BEQ;
          isa_pkg::F3_BNE:  op = isa_pkg::IOP_BNE;
          isa_pkg::F3_BLT:  op = isa_pkg::IOP_BLT;
          isa_pkg::F3_BGE:  op = isa_pkg::IOP_BGE;
          isa_pkg::F3_BLTU: op = isa_pkg::IOP_BLTU;
          isa_pkg::F3_BGEU: op = isa_pkg::IOP_BGEU;
          default:          op = isa_pkg::IOP_INVALID;
        endcase
      end
      default: op = isa_pkg::IOP_INVALID;
    endcase
  end

  ////////////////////
  // Control flags per operation class

  always_comb begin
    ctrl    = '0;
    writes  = 1'b0;
    ctrl.op = op;
    case (op)
      isa_pkg::IOP_ADD, isa_pkg::IOP_SUB, isa_pkg::IOP_AND, isa_pkg::IOP_OR,
      isa_pkg::IOP_XOR, isa_pkg::IOP_SLT, isa_pkg::IOP_SLTU, isa_pkg::IOP_SRA,
      isa_pkg::IOP_SRL, isa_pkg::IOP_SLL, isa_pkg::IOP_MUL: begin
        ctrl.use_rs1 = 1'b1;
        ctrl.use_rs2 = 1'b1;
        writes       = 1'b1;
      end
      isa_pkg::IOP_ADDI, isa_pkg::IOP_ANDI, isa_pkg::IOP_ORI, isa_pkg::IOP_XORI,
      isa_pkg::IOP_SLTI, isa_pkg::IOP_SLTIU, isa_pkg::IOP_SRAI, isa_pkg::IOP_SRLI,
      isa_pkg::IOP_SLLI, isa_pkg::IOP_LW, isa_pkg::IOP_JALR: begin
        ctrl.imm_kind = isa_pkg::IMM_I;
        ctrl.use_rs1  = 1'b1;
        ctrl.rd_mem   = (op == isa_pkg::IOP_LW);
        ctrl.is_jmp   = (op == isa_pkg::IOP_JALR);
        writes        = 1'b1;
      end
      isa_pkg::IOP_LUI, isa_pkg::IOP_AUIPC: begin
        ctrl.imm_kind = isa_pkg::IMM_U; // No register sources
        writes        = 1'b1;
      end
      isa_pkg::IOP_JAL: begin
        ctrl.imm_kind = isa_pkg::IMM_J;
        ctrl.is_jmp   = 1'b1;
        writes        = 1'b1;
      end
      isa_pkg::IOP_SW: begin
        ctrl.imm_kind = isa_pkg::IMM_S;
        ctrl.use_rs1  = 1'b1;
        ctrl.use_rs2  = 1'b1;
        ctrl.wr_mem   = 1'b1;
      end
      isa_pkg::IOP_BEQ, isa_pkg::IOP_BNE, isa_pkg::IOP_BLT,
      isa_pkg::IOP_BGE, isa_pkg::IOP_BLTU, isa_pkg::IOP_BGEU: begin
        ctrl.imm_kind = isa_pkg::IMM_B;
        ctrl.use_rs1  = 1'b1;
        ctrl.use_rs2  = 1'b1;
        ctrl.is_br    = 1'b1;
      end
      default: ctrl.imm_kind = isa_pkg::IMM_NONE;
    endcase
    ctrl.wr_reg = writes && (inst.r.rd != '0); // x0 is never a destination
  end

  // Unknown encodings must reach execute as harmless
  always_comb begin
    if (ctrl.op == isa_pkg::IOP_INVALID) begin
      assert (!ctrl.wr_reg && !ctrl.wr_mem && !ctrl.is_br && !ctrl.is_jmp)
        else $error("invalid op carries side-effect flags");
    end
  end

endmodule

`default_nettype wire

/* isa_pkg.sv */
`default_nettype none

package isa_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  ////////////////////
  // Instruction formats

  typedef struct packed {
    logic [6:0] funct7;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    reg_idx_t   rd;
    opcode_t    opcode;
  } r_fmt_t;

  typedef struct packed {
    logic [11:0] imm;
    reg_idx_t    rs1;
    logic [2:0]  funct3;
    reg_idx_t    rd;
    opcode_t     opcode;
  } i_fmt_t;

  typedef struct packed {
    logic [6:0] imm_11_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [4:0] imm_4_0;
    opcode_t    opcode;
  } s_fmt_t;

  typedef struct packed {
    logic       imm_12;
    logic [5:0] imm_10_5;
    reg_idx_t   rs2;
    reg_idx_t   rs1;
    logic [2:0] funct3;
    logic [3:0] imm_4_1;
    logic       imm_11;
    opcode_t    opcode;
  } b_fmt_t;

  typedef struct packed {
    logic [19:0] imm_31_12;
    reg_idx_t    rd;
    opcode_t     opcode;
  } u_fmt_t;

  typedef struct packed {
    logic       imm_20;
    logic [9:0] imm_10_1;
    logic       imm_11;
    logic [7:0] imm_19_12;
    reg_idx_t   rd;
    opcode_t    opcode;
  } j_fmt_t;

  // One instruction word, six ways to look at it
  typedef union packed {
    r_fmt_t r;
    i_fmt_t i;
    s_fmt_t s;
    b_fmt_t b;
    u_fmt_t u;
    j_fmt_t j;
  } inst_u;

  ////////////////////
  // Major opcodes

  localparam opcode_t OP_OP     = 7'b0110011;
  localparam opcode_t OP_IMM    = 7'b0010011;
  localparam opcode_t OP_LUI    = 7'b0110111;
  localparam opcode_t OP_AUIPC  = 7'b0010111;
  localparam opcode_t OP_LOAD   = 7'b0000011;
  localparam opcode_t OP_STORE  = 7'b0100011;
  localparam opcode_t OP_JAL    = 7'b1101111;
  localparam opcode_t OP_JALR   = 7'b1100111;
  localparam opcode_t OP_BRANCH = 7'b1100011;

  // funct3, ALU group (shared by register and immediate forms)
  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_SLL     = 3'b001;
  localparam logic [2:0] F3_SLT     = 3'b010;
  localparam logic [2:0] F3_SLTU    = 3'b011;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_SRL_SRA = 3'b101;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  localparam logic [2:0] F3_MUL     = 3'b000;

  // funct3, memory, jump and branch
  localparam logic [2:0] F3_LW   = 3'b010;
  localparam logic [2:0] F3_SW   = 3'b010;
  localparam logic [2:0] F3_JALR = 3'b000;
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;

  localparam logic [6:0] F7_BASE = 7'b0000000;
  localparam logic [6:0] F7_ALT  = 7'b0100000; // SUB, SRA, SRAI
  localparam logic [6:0] F7_MUL  = 7'b0000001;

  ////////////////////
  // Internal operation codes

  typedef enum logic [5:0] {
    IOP_INVALID = 6'd0,
    IOP_ADD, IOP_SUB, IOP_AND, IOP_OR, IOP_XOR,
    IOP_SLT, IOP_SLTU, IOP_SRA, IOP_SRL, IOP_SLL, IOP_MUL,
    IOP_ADDI, IOP_ANDI, IOP_ORI, IOP_XORI, IOP_SLTI, IOP_SLTIU,
    IOP_SRAI, IOP_SRLI, IOP_SLLI,
    IOP_LUI, IOP_AUIPC, IOP_LW, IOP_SW, IOP_JAL, IOP_JALR,
    IOP_BEQ, IOP_BNE, IOP_BLT, IOP_BGE, IOP_BLTU, IOP_BGEU
  } iop_e;

  typedef enum logic [2:0] {
    IMM_NONE = 3'd0,
    IMM_I,
    IMM_S,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_kind_e;

endpackage

`default_nettype wire

/* pipe_pkg.sv */
`default_nettype none

package pipe_pkg;

  // Fetch latch, as the fetch stage packs it
  typedef struct packed {
    logic            valid;
    isa_pkg::inst_u  inst;
    isa_pkg::xlen_t  pc;
    isa_pkg::xlen_t  pc_plus;
    isa_pkg::xlen_t  pc_next;
    logic [7:0]      bhr_hash;
  } fe_latch_t;

  // Writeback strobe into the register file and scoreboard
  typedef struct packed {
    logic              en;
    isa_pkg::reg_idx_t rd;
    isa_pkg::xlen_t    value;
  } wb_write_t;

  // Decode latch, read by execute
  typedef struct packed {
    logic              valid;
    isa_pkg::inst_u    inst;
    isa_pkg::xlen_t    pc;
    isa_pkg::xlen_t    pc_plus;
    isa_pkg::xlen_t    pc_next;
    isa_pkg::iop_e     op;
    isa_pkg::xlen_t    rs1_val;
    isa_pkg::xlen_t    rs2_val;
    isa_pkg::xlen_t    imm;
    logic              is_br;
    logic              is_jmp;
    logic              rd_mem;  // Load
    logic              wr_mem;  // Store
    logic              wr_reg;
    isa_pkg::reg_idx_t rd;
    logic [7:0]        bhr_hash;
  } de_latch_t;

  // Decoder control bundle
  typedef struct packed {
    isa_pkg::iop_e      op;
    isa_pkg::imm_kind_e imm_kind;
    logic               use_rs1;
    logic               use_rs2;
    logic               is_br;
    logic               is_jmp;
    logic               rd_mem;
    logic               wr_mem;
    logic               wr_reg;
  } dec_ctrl_t;

endpackage

`default_nettype wire

/* reg_file.sv */
`timescale 1ns/1ps
`default_nettype none

module reg_file (
  input  wire                      clk,
  input  wire                      reset,
  input  wire isa_pkg::reg_idx_t   rs1,
  input  wire isa_pkg::reg_idx_t   rs2,
  input  wire pipe_pkg::wb_write_t wb,
  output isa_pkg::xlen_t           rs1_val,
  output isa_pkg::xlen_t           rs2_val
);

  isa_pkg::xlen_t regs [32];

  // Read with x0 forced to zero and same-cycle writeback forwarded
  function automatic isa_pkg::xlen_t read_port(isa_pkg::reg_idx_t idx);
    if (idx == '0)
      return '0;
    else if (wb.en && wb.rd == idx)
      return wb.value;
    else
      return regs[idx];
  endfunction

  initial begin
    for (int i = 0; i < 32; i++)
      regs[i] = '0;
  end

  always @(posedge clk) begin
    if (wb.en && wb.rd != '0) // x0 is hardwired
      regs[wb.rd] <= wb.value;
  end

  always_comb begin
    rs1_val = read_port(rs1);
    rs2_val = read_port(rs2);
  end

  a_x0_zero: assert property (@(posedge clk) disable iff (reset) regs[0] == '0)
    else $error("x0 holds a nonzero value");

endmodule

`default_nettype wire

/* scoreboard.sv */
`timescale 1ns/1ps
`default_nettype none

module scoreboard (
  input  wire                      clk,
  input  wire                      reset,
  input  wire                      valid,
  input  wire isa_pkg::reg_idx_t   rs1,
  input  wire isa_pkg::reg_idx_t   rs2,
  input  wire isa_pkg::reg_idx_t   rd,
  input  wire                      use_rs1,
  input  wire                      use_rs2,
  input  wire                      wr_reg,
  input  wire                      br_mispred,
  input  wire pipe_pkg::wb_write_t wb,
  output logic                     stall
);

  logic [31:0] busy; // One bit per register with a result still in flight
  logic        raw_hazard;

  assign raw_hazard = valid && ((use_rs1 && busy[rs1]) || (use_rs2 && busy[rs2]));
  assign stall      = br_mispred || raw_hazard;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= '0;
    end else begin
      if (valid && wr_reg && !stall)
        busy[rd] <= 1'b1;
      if (wb.en)
        busy[wb.rd] <= 1'b0; // Later assignment, so a clear beats a set
    end
  end

  // Every retiring write was reserved when it passed decode
  a_wb_reserved: assert property (@(posedge clk) disable iff (reset)
    (wb.en && wb.rd != '0) |-> busy[wb.rd])
    else $error("writeback to x%0d without a scoreboard entry", wb.rd);

endmodule

`default_nettype wire

/* tb_decode_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_decode_stage;

  localparam int    CLK_PERIOD   = 40;
  localparam int    RESET_CYCLES = 4;
  localparam int    SAMPLE_DELAY = CLK_PERIOD / 2 - 2; // Just ahead of the rising edge
  localparam string CASE_FILE    = "de_cases.txt";

  // One case line and the decode latch it should produce
  typedef struct packed {
    logic [31:0]         line_no;
    pipe_pkg::fe_latch_t fe;
    logic                br_mispred;
    pipe_pkg::wb_write_t wb;
    logic                exp_stall;
    pipe_pkg::de_latch_t exp_latch;
  } case_t;

  logic                clk = 1'b0;
  logic                reset;
  pipe_pkg::fe_latch_t fe_latch;
  logic                br_mispred;
  pipe_pkg::wb_write_t wb;
  logic                stall;
  pipe_pkg::de_latch_t de_latch_out;

  case_t cases[$];
  bit    cases_loaded = 1'b0;

  decode_stage DUT (
    .clk          (clk),
    .reset        (reset),
    .fe_latch     (fe_latch),
    .br_mispred   (br_mispred),
    .wb           (wb),
    .stall        (stall),
    .de_latch_out (de_latch_out)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  ////////////////////
  // Failure and compare tasks

  task automatic stop_with_failure(input string reason);
    $display("%s", reason);
    $display("Regression failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_stall(input string name, input logic expected, input logic actual);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED %s stall expected %0b actual %0b",
                                  name, expected, actual));
  endtask

  task automatic check_latch(input string name, input pipe_pkg::de_latch_t expected,
                             input pipe_pkg::de_latch_t actual);
    if (actual !== expected)
      stop_with_failure($sformatf("FAILED %s de_latch_out expected %h actual %h",
                                  name, expected, actual));
  endtask

  ////////////////////
  // Case file reader

  task automatic load_cases();
    int          fd;
    int          line_no;
    int          fields;
    string       text;
    logic        valid;
    logic [31:0] inst;
    logic [31:0] pc;
    logic [7:0]  bhr;
    logic        mispred;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_value;
    logic        exp_stall;
    logic [5:0]  exp_op;
    logic [31:0] exp_rs1;
    logic [31:0] exp_rs2;
    logic [31:0] exp_imm;
    logic [4:0]  exp_flags;
    case_t       c;

    line_no = 0;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0)
      stop_with_failure({"Could not open the case file ", CASE_FILE});
    while ($fgets(text, fd) != 0) begin
      line_no++;
      if (text.len() < 2 || text.substr(0, 1) == "//")
        continue; // Blank or comment line
      fields = $sscanf(text, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                       valid, inst, pc, bhr, mispred, wb_en, wb_rd, wb_value,
                       exp_stall, exp_op, exp_rs1, exp_rs2, exp_imm, exp_flags);
      if (fields != 14)
        stop_with_failure($sformatf("Line %0d of %s does not hold 14 fields",
                                    line_no, CASE_FILE));
      c              = '0;
      c.line_no      = line_no;
      c.fe.valid     = valid;
      c.fe.inst      = inst;
      c.fe.pc        = pc;
      c.fe.pc_plus   = pc + 32'd4;
      c.fe.pc_next   = pc + 32'd8;  // Kept apart from pc_plus so a swap shows
      c.fe.bhr_hash  = bhr;
      c.br_mispred   = mispred;
      c.wb.en        = wb_en;
      c.wb.rd        = wb_rd;
      c.wb.value     = wb_value;
      c.exp_stall    = exp_stall;
      // A stalled slot leaves an all-zero bubble
      if (!exp_stall) begin
        c.exp_latch.valid    = valid;
        c.exp_latch.inst     = inst;
        c.exp_latch.pc       = c.fe.pc;
        c.exp_latch.pc_plus  = c.fe.pc_plus;
        c.exp_latch.pc_next  = c.fe.pc_next;
        c.exp_latch.op       = isa_pkg::iop_e'(exp_op);
        c.exp_latch.rs1_val  = exp_rs1;
        c.exp_latch.rs2_val  = exp_rs2;
        c.exp_latch.imm      = exp_imm;
        {c.exp_latch.is_br, c.exp_latch.is_jmp, c.exp_latch.rd_mem,
         c.exp_latch.wr_mem, c.exp_latch.wr_reg} = exp_flags;
        c.exp_latch.rd       = inst[11:7]; // Raw bits 11:7 whatever the format
        c.exp_latch.bhr_hash = bhr;
      end
      cases.push_back(c);
    end
    $fclose(fd);
  endtask

  task automatic apply_case(input case_t c);
    fe_latch   = c.fe;
    br_mispred = c.br_mispred;
    wb         = c.wb;
  endtask

  ////////////////////
  // Main sequence

  initial begin
    string name;

    reset          = 1'b1;
    fe_latch       = '0;
    fe_latch.valid = 1'b1;
    fe_latch.inst  = 32'h0020_8033; // add x0, x1, x2 reads two scoreboard bits
    br_mispred     = 1'b0;
    wb             = '0;
    load_cases();
    cases_loaded = 1'b1;

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    check_stall("after reset", 1'b0, stall);
    check_latch("after reset", '0, de_latch_out);
    reset = 1'b0;

    foreach (cases[i]) begin
      name = $sformatf("case line %0d", cases[i].line_no);
      apply_case(cases[i]);           // On the falling edge
      #(SAMPLE_DELAY);
      check_stall(name, cases[i].exp_stall, stall);
      @(posedge clk);
      @(negedge clk);
      check_latch(name, cases[i].exp_latch, de_latch_out);
    end

    fe_latch   = '0;
    br_mispred = 1'b0;
    wb         = '0;
    if (cases.size() == 0) begin
      stop_with_failure({"No cases were found in ", CASE_FILE});
    end else begin
      $display("Regression passed");
      $finish;
    end
  end

  // Watchdog sized from the number of cases
  initial begin
    wait (cases_loaded);
    #((cases.size() + 10) * CLK_PERIOD);
    stop_with_failure("Timeout, the watchdog expired before all cases were checked");
  end

endmodule

`default_nettype wire
